// File: Makefile
VERILATOR ?= verilator
TOP       ?= conv_kernel_tb
FILELIST  ?= files.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

// File: files.f
source/conv_pkg.sv
source/conv_ifs.sv
source/weight_store.sv
source/feature_padding.sv
source/line_buffer.sv
source/window_3x3.sv
source/mac_array.sv
source/conv_kernel_top.sv
tests/conv_kernel_tb.sv

// File: source/conv_ifs.sv
// three-row column of one padded position
interface line_if import conv_pkg::*; ();

        word_t                  top;
        word_t                  mid;
        word_t                  bot;
        logic [DIM_W-1:0]       col;
        logic [DIM_W-1:0]       row;
        logic                   vld;

        modport source (
                output top, mid, bot, col, row, vld
        );

        modport sink (
                input  top, mid, bot, col, row, vld
        );

endinterface

// one 3x3 window per input channel
interface window_if import conv_pkg::*; ();

        kernel_t [NUM_CH-1:0]   win;
        logic                   vld;
        logic                   last;

        modport source (
                output win, vld, last
        );

        modport sink (
                input  win, vld, last
        );

endinterface

// File: source/conv_kernel_top.sv
module conv_kernel_top import conv_pkg::*; (
        input  logic                    sclk,
        input  logic                    arst_n,
        input  logic                    start,
        input  logic [DIM_W-1:0]        rows,
        input  logic [DIM_W-1:0]        cols,
        output logic                    buffer_rd_en,
        input  word_t                   buffer_rd_data,
        input  logic                    weight_req,
        input  logic [WADDR_W-1:0]      weight_addr,
        input  logic [TAPS*PIX_W-1:0]   weight_data,
        output logic                    weight_ack,
        output out_t [NUM_CH-1:0]       conv_out,
        output logic                    conv_vld,
        output logic                    conv_finish
);

kernel_t [KERNELS-1:0]  kernels;
acc_t [NUM_CH-1:0]      biases;

line_if                 pad_line ();
line_if                 buf_line ();
window_if               win_bus ();

// ==========================================================
// pipeline: padding -> lines -> window -> mac
// ==========================================================
weight_store i_weight_store (
        .sclk           (sclk           ),
        .arst_n         (arst_n         ),
        .weight_req     (weight_req     ),
        .weight_addr    (weight_addr    ),
        .weight_data    (weight_data    ),
        .weight_ack     (weight_ack     ),
        .kernels        (kernels        ),
        .biases         (biases         )
);

feature_padding i_feature_padding (
        .sclk           (sclk           ),
        .arst_n         (arst_n         ),
        .start          (start          ),
        .rows           (rows           ),
        .cols           (cols           ),
        .buffer_rd_en   (buffer_rd_en   ),
        .buffer_rd_data (buffer_rd_data ),
        .line           (pad_line       )
);

line_buffer i_line_buffer (
        .sclk           (sclk           ),
        .arst_n         (arst_n         ),
        .cols           (cols           ),
        .pix            (pad_line       ),
        .line           (buf_line       )
);

window_3x3 i_window_3x3 (
        .sclk           (sclk           ),
        .arst_n         (arst_n         ),
        .rows           (rows           ),
        .cols           (cols           ),
        .line           (buf_line       ),
        .win            (win_bus        )
);

mac_array i_mac_array (
        .sclk           (sclk           ),
        .arst_n         (arst_n         ),
        .win            (win_bus        ),
        .kernels        (kernels        ),
        .biases         (biases         ),
        .conv_out       (conv_out       ),
        .conv_vld       (conv_vld       ),
        .conv_finish    (conv_finish    )
);

endmodule

// File: source/conv_pkg.sv
package conv_pkg;

// ==========================================================
// sizes
// ==========================================================
localparam int NUM_CH    = 4;
localparam int PIX_W     = 8;
localparam int WORD_W    = NUM_CH * PIX_W;
localparam int KSIZE     = 3;
localparam int TAPS      = KSIZE * KSIZE;
localparam int MAX_DIM   = 64;
localparam int DIM_W     = 7;
localparam int COL_AW    = $clog2(MAX_DIM);
localparam int CH_W      = $clog2(NUM_CH);

// arithmetic
localparam int PROD_W    = 2 * PIX_W;
localparam int ACC_W     = 32;
localparam int OUT_W     = 24;
localparam int OUT_SHIFT = 4;

// weight address map, kernels at oc*4+ic, then biases
localparam int WADDR_W   = 5;
localparam int KERNELS   = NUM_CH * NUM_CH;
localparam int KIDX_W    = $clog2(KERNELS);
localparam int BIAS_BASE = 16;

typedef logic signed [PIX_W-1:0]        pixel_t;
typedef pixel_t [NUM_CH-1:0]            word_t;
typedef pixel_t [TAPS-1:0]              kernel_t;
typedef logic signed [PROD_W-1:0]       prod_t;
typedef logic signed [ACC_W-1:0]        acc_t;
typedef logic signed [OUT_W-1:0]        out_t;

localparam acc_t SAT_MAX = acc_t'(2 ** (OUT_W - 1) - 1);
localparam acc_t SAT_MIN = acc_t'(-(2 ** (OUT_W - 1)));

endpackage

// File: source/feature_padding.sv
module feature_padding import conv_pkg::*; (
        input  logic                    sclk,
        input  logic                    arst_n,
        input  logic                    start,
        input  logic [DIM_W-1:0]        rows,
        input  logic [DIM_W-1:0]        cols,
        output logic                    buffer_rd_en,
        input  word_t                   buffer_rd_data,
        line_if.source                  line
);

logic                   busy;
logic [DIM_W-1:0]       row_cnt;
logic [DIM_W-1:0]       col_cnt;
logic                   row_end;
logic                   frame_end;
logic                   interior;

logic                   pad_vld;
logic                   pad_border;
logic [DIM_W-1:0]       pad_row;
logic [DIM_W-1:0]       pad_col;

// padded frame is (rows+2) x (cols+2)
assign row_end   = col_cnt == cols + DIM_W'(1);
assign frame_end = row_end && (row_cnt == rows + DIM_W'(1));
assign interior  = (row_cnt != '0) && (row_cnt <= rows) &&
                   (col_cnt != '0) && (col_cnt <= cols);

assign buffer_rd_en = busy && interior;

// ==========================================================
// padded position walk
// ==========================================================
always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
                busy    <= 1'b0;
                row_cnt <= '0;
                col_cnt <= '0;
        end else if (!busy) begin
                // start only counts while idle
                if (start) begin
                        busy    <= 1'b1;
                        row_cnt <= '0;
                        col_cnt <= '0;
                end
        end else begin
                if (frame_end) begin
                        busy <= 1'b0;
                end
                if (row_end) begin
                        col_cnt <= '0;
                        row_cnt <= row_cnt + DIM_W'(1);
                end else begin
                        col_cnt <= col_cnt + DIM_W'(1);
                end
        end
end

// ==========================================================
// tags follow the one-cycle buffer read latency
// ==========================================================
always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
                pad_vld <= 1'b0;
        end else begin
                pad_vld <= busy;
        end
end

always_ff @(posedge sclk) begin
        pad_border <= !interior;
        pad_row    <= row_cnt;
        pad_col    <= col_cnt;
end

// zero word on the border
assign line.bot = pad_border ? word_t'({WORD_W{1'b0}}) : buffer_rd_data;
assign line.row = pad_row;
assign line.col = pad_col;
assign line.vld = pad_vld;

// upper rows come from line_buffer
assign line.top = '0;
assign line.mid = '0;

endmodule

// File: source/line_buffer.sv
module line_buffer import conv_pkg::*; (
        input  logic                    sclk,
        input  logic                    arst_n,
        input  logic [DIM_W-1:0]        cols,
        line_if.sink                    pix,
        line_if.source                  line
);

// interior columns only, the border columns are always zero
word_t                  mem_top [MAX_DIM];
word_t                  mem_mid [MAX_DIM];

logic                   edge_col;
logic [DIM_W-1:0]       col_m1;
logic [COL_AW-1:0]      idx;

assign edge_col = (pix.col == '0) || (pix.col == cols + DIM_W'(1));
assign col_m1   = pix.col - DIM_W'(1);
assign idx      = col_m1[COL_AW-1:0];

// ==========================================================
// row storage
// ==========================================================
// row r-1 moves up to r-2, new row goes in as r-1
always_ff @(posedge sclk) begin
        if (pix.vld && !edge_col) begin
                mem_top[idx] <= mem_mid[idx];
                mem_mid[idx] <= pix.bot;
        end
end

// ==========================================================
// column output
// ==========================================================
always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
                line.vld <= 1'b0;
        end else begin
                line.vld <= pix.vld;
        end
end

always_ff @(posedge sclk) begin
        line.top <= edge_col ? '0 : mem_top[idx];
        line.mid <= edge_col ? '0 : mem_mid[idx];
        line.bot <= pix.bot;
        line.row <= pix.row;
        line.col <= pix.col;
end

endmodule

// File: source/mac_array.sv
module mac_array import conv_pkg::*; (
        input  logic                    sclk,
        input  logic                    arst_n,
        window_if.sink                  win,
        input  kernel_t [KERNELS-1:0]   kernels,
        input  acc_t [NUM_CH-1:0]       biases,
        output out_t [NUM_CH-1:0]       conv_out,
        output logic                    conv_vld,
        output logic                    conv_finish
);

prod_t                  prod_q [NUM_CH][NUM_CH][TAPS];
acc_t                   sum_c [NUM_CH];
acc_t                   acc_q [NUM_CH];
acc_t                   shift_c [NUM_CH];
out_t                   sat_c [NUM_CH];

logic                   vld_s1;
logic                   vld_s2;
logic                   last_s1;
logic                   last_s2;
logic                   last_s3;

// ==========================================================
// stage 1, products
// ==========================================================
always_ff @(posedge sclk) begin
        for (int oc = 0; oc < NUM_CH; oc++) begin
                for (int ic = 0; ic < NUM_CH; ic++) begin
                        for (int t = 0; t < TAPS; t++) begin
                                prod_q[oc][ic][t] <= $signed(win.win[ic][t]) *
                                        $signed(kernels[oc*NUM_CH + ic][t]);
                        end
                end
        end
end

// ==========================================================
// stage 2, adder tree plus bias
// ==========================================================
always_comb begin
        for (int oc = 0; oc < NUM_CH; oc++) begin
                sum_c[oc] = $signed(biases[oc]);
                for (int ic = 0; ic < NUM_CH; ic++) begin
                        for (int t = 0; t < TAPS; t++) begin
                                sum_c[oc] = sum_c[oc] + acc_t'(prod_q[oc][ic][t]);
                        end
                end
        end
end

always_ff @(posedge sclk) begin
        acc_q <= sum_c;
end

// ==========================================================
// stage 3, shift and saturate
// ==========================================================
always_comb begin
        for (int oc = 0; oc < NUM_CH; oc++) begin
                shift_c[oc] = acc_q[oc] >>> OUT_SHIFT;
                if (shift_c[oc] > SAT_MAX) begin
                        sat_c[oc] = out_t'(SAT_MAX);
                end else if (shift_c[oc] < SAT_MIN) begin
                        sat_c[oc] = out_t'(SAT_MIN);
                end else begin
                        sat_c[oc] = shift_c[oc][OUT_W-1:0];
                end
        end
end

always_ff @(posedge sclk) begin
        for (int oc = 0; oc < NUM_CH; oc++) begin
                conv_out[oc] <= sat_c[oc];
        end
end

// valid and last travel with the data
always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
                {vld_s1, vld_s2, conv_vld}        <= '0;
                {last_s1, last_s2, last_s3}       <= '0;
                conv_finish                       <= 1'b0;
        end else begin
                {vld_s1, vld_s2, conv_vld}        <= {win.vld, vld_s1, vld_s2};
                {last_s1, last_s2, last_s3}       <= {win.vld && win.last, last_s1, last_s2};
                conv_finish                       <= last_s3;
        end
end

endmodule

// File: source/weight_store.sv
module weight_store import conv_pkg::*; (
        input  logic                            sclk,
        input  logic                            arst_n,
        input  logic                            weight_req,
        input  logic [WADDR_W-1:0]              weight_addr,
        input  logic [TAPS*PIX_W-1:0]           weight_data,
        output logic                            weight_ack,
        output kernel_t [KERNELS-1:0]           kernels,
        output acc_t [NUM_CH-1:0]               biases
);

logic                   wr_en;
logic                   is_kernel;
logic                   is_bias;

// write once per request, on the req rising phase
assign wr_en     = weight_req && !weight_ack;
assign is_kernel = weight_addr < WADDR_W'(KERNELS);
assign is_bias   = (weight_addr >= WADDR_W'(BIAS_BASE)) &&
                   (weight_addr < WADDR_W'(BIAS_BASE + NUM_CH));

// ==========================================================
// four-phase handshake
// ==========================================================
always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
                weight_ack <= 1'b0;
        end else if (wr_en) begin
                weight_ack <= 1'b1;
        end else if (!weight_req && weight_ack) begin
                weight_ack <= 1'b0;
        end
end

// ==========================================================
// register file
// ==========================================================
always_ff @(posedge sclk) begin
        if (wr_en && is_kernel) begin
                kernels[weight_addr[KIDX_W-1:0]] <= kernel_t'(weight_data);
        end
end

// bias takes the low word of the data bus
always_ff @(posedge sclk) begin
        if (wr_en && is_bias) begin
                biases[weight_addr[CH_W-1:0]] <= weight_data[ACC_W-1:0];
        end
end

endmodule

// File: source/window_3x3.sv
module window_3x3 import conv_pkg::*; (
        input  logic                    sclk,
        input  logic                    arst_n,
        input  logic [DIM_W-1:0]        rows,
        input  logic [DIM_W-1:0]        cols,
        line_if.sink                    line,
        window_if.source                win
);

// index 0 is the left, oldest column
word_t [KSIZE-1:0]      win_top;
word_t [KSIZE-1:0]      win_mid;
word_t [KSIZE-1:0]      win_bot;
kernel_t [NUM_CH-1:0]   win_data;

logic                   centre_ok;
logic                   at_last;

// window centre must be an interior pixel
assign centre_ok = (line.row >= DIM_W'(2)) && (line.col >= DIM_W'(2));
assign at_last   = (line.row == rows + DIM_W'(1)) && (line.col == cols + DIM_W'(1));

always_ff @(posedge sclk) begin
        if (line.vld) begin
                win_top <= {line.top, win_top[KSIZE-1:1]};
                win_mid <= {line.mid, win_mid[KSIZE-1:1]};
                win_bot <= {line.bot, win_bot[KSIZE-1:1]};
        end
end

always_ff @(posedge sclk or negedge arst_n) begin
        if (!arst_n) begin
                win.vld  <= 1'b0;
                win.last <= 1'b0;
        end else begin
                win.vld  <= line.vld && centre_ok;
                win.last <= line.vld && at_last;
        end
end

// raster order taps, top-left first
always_comb begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
                for (int c = 0; c < KSIZE; c++) begin
                        win_data[ch][c]           = win_top[c][ch];
                        win_data[ch][KSIZE + c]   = win_mid[c][ch];
                        win_data[ch][2*KSIZE + c] = win_bot[c][ch];
                end
        end
end

assign win.win = win_data;

endmodule

// File: tests/conv_kernel_tb.sv
module conv_kernel_tb import conv_pkg::*; ();

logic                   sclk;
logic                   arst_n;
logic                   start;
logic [DIM_W-1:0]       rows;
logic [DIM_W-1:0]       cols;
logic                   buffer_rd_en;
word_t                  buffer_rd_data;
logic                   weight_req;
logic [WADDR_W-1:0]     weight_addr;
logic [TAPS*PIX_W-1:0]  weight_data;
logic                   weight_ack;
out_t [NUM_CH-1:0]      conv_out;
logic                   conv_vld;
logic                   conv_finish;

// kind in the low nibble with the payload above it
logic [99:0]            trace [0:511];
logic [WORD_W-1:0]      pix_q [$];
logic [95:0]            exp_q [$];

int                     errors = 0;
int                     vld_cnt;
int                     rd_cnt;
int                     finish_cnt;
int                     frame_total;
int                     limit;
logic                   limit_ready = 1'b0;
logic                   rd_pending = 1'b0;
logic                   prev_vld = 1'b0;

conv_kernel_top i_conv_kernel_top (
        .sclk           (sclk           ),
        .arst_n         (arst_n         ),
        .start          (start          ),
        .rows           (rows           ),
        .cols           (cols           ),
        .buffer_rd_en   (buffer_rd_en   ),
        .buffer_rd_data (buffer_rd_data ),
        .weight_req     (weight_req     ),
        .weight_addr    (weight_addr    ),
        .weight_data    (weight_data    ),
        .weight_ack     (weight_ack     ),
        .conv_out       (conv_out       ),
        .conv_vld       (conv_vld       ),
        .conv_finish    (conv_finish    )
);

always #2 sclk = ~sclk;

task automatic check_value(input string name, input logic [95:0] got, input logic [95:0] exp);
        if (got !== exp) begin
                $display("** Error: %s got %h expected %h", name, got, exp);
                errors++;
        end
endtask

// four-phase write with ack following req both ways
task automatic load_weight(input logic [WADDR_W-1:0] addr, input logic [71:0] data);
        int n;
        check_value("weight_ack", weight_ack, 0);
        weight_addr = addr;
        weight_data = data;
        weight_req  = 1'b1;
        n = 0;
        while (weight_ack !== 1'b1 && n < 8) begin
                @(posedge sclk);
                #1;
                n++;
        end
        if (weight_ack !== 1'b1) begin
                $display("no weight ack within 8 cycles for address %0d", addr);
                errors++;
        end else begin
                // ack holds while the request is still up
                @(posedge sclk);
                #1;
                check_value("weight_ack", weight_ack, 1);
        end
        weight_req = 1'b0;
        n = 0;
        while (weight_ack !== 1'b0 && n < 8) begin
                @(posedge sclk);
                #1;
                n++;
        end
        if (weight_ack !== 1'b0) begin
                $display("weight ack still high 8 cycles after request dropped, address %0d", addr);
                errors++;
        end
        @(posedge sclk);
        #1;
endtask

// ==========================================================
// buffer model and output monitor
// ==========================================================
always @(negedge sclk) begin
        if (buffer_rd_en === 1'b1) begin
                rd_cnt++;
                rd_pending = 1'b1;
        end
        if (conv_vld === 1'b1) begin
                vld_cnt++;
                if (exp_q.size() == 0) begin
                        $display("output beyond the expected count of the frame");
                        errors++;
                end else begin
                        check_value("conv_out", conv_out, exp_q.pop_front());
                end
        end
        if (conv_finish === 1'b1) begin
                finish_cnt++;
                check_value("finish output count", vld_cnt, frame_total);
                check_value("conv_vld before finish", prev_vld, 1);
        end
        prev_vld = conv_vld;
end

always @(posedge sclk) begin
        #1;
        if (rd_pending) begin
                rd_pending = 1'b0;
                if (pix_q.size() == 0) begin
                        $display("buffer read with no pixel words left");
                        errors++;
                end else begin
                        buffer_rd_data = pix_q.pop_front();
                end
        end
end

initial begin
        wait (limit_ready);
        repeat (limit) @(posedge sclk);
        $display("watchdog expired after %0d cycles", limit);
        $display("Test failed");
        $finish;
end

initial begin
        int i;
        int tests;
        int err0;
        int nw;
        sclk = 1'b0;
        arst_n = 1'b0;
        start = 1'b0;
        rows = '0;
        cols = '0;
        buffer_rd_data = '0;
        weight_req = 1'b0;
        weight_addr = '0;
        weight_data = '0;
        tests = 0;
        $readmemh("tests/conv_trace.txt", trace);
        // 20 cycles per padded pixel plus slack
        limit = 200;
        for (i = 0; trace[i][3:0] != 4'h0; i++) begin
                if (trace[i][3:0] == 4'h2) begin
                        limit += 20 * (trace[i][19:12] + 2) * (trace[i][11:4] + 2);
                end
        end
        limit_ready = 1'b1;
        repeat (16) @(posedge sclk);
        #1;
        arst_n = 1'b1;
        check_value("buffer_rd_en", buffer_rd_en, 0);
        check_value("conv_vld", conv_vld, 0);
        check_value("conv_finish", conv_finish, 0);
        check_value("weight_ack", weight_ack, 0);
        i = 0;
        while (trace[i][3:0] != 4'h0) begin
                err0 = errors;
                if (trace[i][3:0] == 4'h1) begin
                        nw = 0;
                        while (trace[i][3:0] == 4'h1) begin
                                load_weight(trace[i][8:4], trace[i][83:12]);
                                nw++;
                                i++;
                        end
                        $display("weight load: %0d writes, %0d errors", nw, errors - err0);
                end else begin
                        rows = trace[i][18:12];
                        cols = trace[i][10:4];
                        frame_total = rows * cols;
                        i++;
                        while (trace[i][3:0] == 4'h3 || trace[i][3:0] == 4'h4) begin
                                if (trace[i][3:0] == 4'h3) begin
                                        pix_q.push_back(trace[i][35:4]);
                                end else begin
                                        exp_q.push_back(trace[i][99:4]);
                                end
                                i++;
                        end
                        vld_cnt = 0;
                        rd_cnt = 0;
                        finish_cnt = 0;
                        start = 1'b1;
                        @(posedge sclk);
                        #1;
                        start = 1'b0;
                        repeat (4) @(posedge sclk);
                        #1;
                        // busy engine must ignore this one
                        start = 1'b1;
                        @(posedge sclk);
                        #1;
                        start = 1'b0;
                        wait (finish_cnt != 0);
                        repeat (8) @(posedge sclk);
                        #1;
                        check_value("conv_vld count", vld_cnt, frame_total);
                        check_value("buffer_rd_en count", rd_cnt, frame_total);
                        check_value("conv_finish count", finish_cnt, 1);
                        check_value("expected words left", exp_q.size(), 0);
                        $display("frame %0dx%0d: %0d outputs, %0d errors",
                                 rows, cols, vld_cnt, errors - err0);
                end
                tests++;
        end
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
                $display("Test completed successfully");
        end else begin
                $display("Test failed");
        end
        $finish;
end

endmodule

// File: tests/conv_trace.txt
// hex records, low digit is the kind: 1 weight {data,addr}, 2 frame {rows,cols}
// 3 pixel word {ch3..ch0}, 4 expected output {out3..out0}, 0 ends the trace
101010101010101010001 011 021 031 041 1000000000051 061 071
081 091 100a1 0b1 0c1 0d1 0e1 f0000000000f1 101 111 121 100131
2032
807fff783 7f5002013 0060fd023 101104033 0122fb043 2033066e3
000090000000ffffff0000804 ffff910000000000020000f04 000010000000fffffd0000754
0000000000000000040000804 00000f00007ffffffb0000f04 fffff00000500000060000754
0a1 7f807f0000000f1 40000000101 c0000000111 07fffff0121 131
1042
643322113 ce0102033 03fefdfc3 7f7f80803
fffb537fffff8000007fffff4 0004c17fffff8000007fffff4
00024b7fffff8000007fffff4 fffc1f7fffff8000007fffff4
0
